/* vlog.f */
+incdir+.
rv_decode_pkg.sv
decode_control.sv
imm_gen.sv
hazard_unit.sv
branch_unit.sv
decode_stage.sv
decode_stage_props.sv
tb_decode_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the decode stage testbench with Verilator
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module tb_decode_stage -f vlog.f -o sim_decode \
  && ./obj_dir/sim_decode > sim.log 2>&1
cat sim.log 2>/dev/null
# A log with the fail message, or no log at all, is a failed run
grep -q "Test failed" sim.log 2>/dev/null && exit 1
grep -q "Test completed successfully" sim.log 2>/dev/null || exit 1
exit 0

/* tb_decode_model.svh */
// Reference decode model, written per control bit instead of per opcode

id_ex_t sh_id_ex;
logic   sh_flush;

function automatic logic legal_encoding(xlen_t i);
  logic [2:0] f3;
  logic [6:0] f7;
  f3 = i[14:12];
  f7 = i[31:25];
  case (i[6:0])
    OP_LUI, OP_AUIPC, OP_JAL: return 1'b1;
    OP_JALR:   return f3 == 3'd0;
    OP_BRANCH: return !(f3 inside {3'd2, 3'd3});
    OP_LOAD:   return f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
    OP_STORE:  return f3 < 3'd3;
    OP_IMM:    return (f3 == 3'd1) ? (f7 == 7'h00) :
                      (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
    OP_REG:    return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
    OP_SYSTEM: return i == INSTR_ECALL;
    default:   return 1'b0;
  endcase
endfunction

function automatic ctrl_t expected_ctrl(xlen_t i);
  ctrl_t      c;
  logic [6:0] op;
  logic [2:0] f3;
  logic       alu_grp;
  op = i[6:0];
  f3 = i[14:12];
  c  = '0;
  if (!legal_encoding(i)) begin
    c.illegal = 1'b1;
    return c;
  end
  alu_grp       = (op == OP_IMM) || (op == OP_REG);
  c.reg_write   = alu_grp || (op inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_LOAD});
  c.alu_src_imm = op inside {OP_IMM, OP_LUI, OP_AUIPC, OP_JALR, OP_LOAD, OP_STORE};
  c.mem_read    = op == OP_LOAD;
  c.mem_write   = op == OP_STORE;
  c.mem_size    = (c.mem_read || c.mem_write) ? f3 : 3'd0;
  c.branch      = op == OP_BRANCH;
  c.jal         = op == OP_JAL;
  c.jalr        = op == OP_JALR;
  c.lui         = op == OP_LUI;
  c.auipc       = op == OP_AUIPC;
  c.uses_rs1    = alu_grp || (op inside {OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE});
  c.uses_rs2    = op inside {OP_REG, OP_BRANCH, OP_STORE};
  if (c.lui) begin
    c.alu_op = ALU_PASS_B;
  end else if (c.branch) begin
    c.alu_op = ALU_SUB;
  end else if (alu_grp) begin
    // Bit 30 picks SUB and SRA
    case (f3)
      3'd0:    c.alu_op = (op == OP_REG && i[30]) ? ALU_SUB : ALU_ADD;
      3'd1:    c.alu_op = ALU_SLL;
      3'd2:    c.alu_op = ALU_SLT;
      3'd3:    c.alu_op = ALU_SLTU;
      3'd4:    c.alu_op = ALU_XOR;
      3'd5:    c.alu_op = i[30] ? ALU_SRA : ALU_SRL;
      3'd6:    c.alu_op = ALU_OR;
      default: c.alu_op = ALU_AND;
    endcase
  end
  return c;
endfunction

// Sign extension by arithmetic shift of a left-aligned field
function automatic xlen_t expected_imm(xlen_t i);
  logic signed [31:0] s;
  case (i[6:0])
    OP_IMM, OP_LOAD, OP_JALR: begin
      s = {i[31:20], 20'h0};
      return s >>> 20;
    end
    OP_STORE: begin
      s = {i[31:25], i[11:7], 20'h0};
      return s >>> 20;
    end
    OP_BRANCH: begin
      s = {i[31], i[7], i[30:25], i[11:8], 1'b0, 19'h0};
      return s >>> 19;
    end
    OP_JAL: begin
      s = {i[31], i[19:12], i[20], i[30:21], 1'b0, 11'h0};
      return s >>> 11;
    end
    OP_LUI, OP_AUIPC: return {i[31:12], 12'h0};
    default: return '0;
  endcase
endfunction

function automatic xlen_t forwarded_operand(reg_idx_t r, xlen_t raw);
  if (r == 5'd0) begin
    return '0;
  end
  if (ex_mem.reg_write && !ex_mem.mem_read && ex_mem.rd == r) begin
    return ex_mem.result;
  end
  if (mem_wb.reg_write && mem_wb.rd == r) begin
    return mem_wb.result;
  end
  return raw;
endfunction

task automatic predict_outputs(output logic e_stall, output redirect_t e_redir,
                               output logic e_ecall);
  ctrl_t    c;
  reg_idx_t r1;
  reg_idx_t r2;
  logic     v;
  logic     dep_ex;
  logic     dep_mem;
  logic     early;
  logic     cond;
  xlen_t    a;
  xlen_t    b;
  xlen_t    im;
  c       = expected_ctrl(if_id.instr);
  r1      = if_id.instr[19:15];
  r2      = if_id.instr[24:20];
  v       = if_id.valid && !sh_flush;
  dep_ex  = (c.uses_rs1 && r1 != 5'd0 && r1 == sh_id_ex.rd) ||
            (c.uses_rs2 && r2 != 5'd0 && r2 == sh_id_ex.rd);
  dep_mem = (c.uses_rs1 && r1 != 5'd0 && r1 == ex_mem.rd) ||
            (c.uses_rs2 && r2 != 5'd0 && r2 == ex_mem.rd);
  early   = c.branch || c.jalr;
  e_stall = v && ((sh_id_ex.ctrl.mem_read && dep_ex) ||
                  (early && sh_id_ex.ctrl.reg_write && dep_ex) ||
                  (early && ex_mem.mem_read && ex_mem.reg_write && dep_mem));
  a  = forwarded_operand(r1, if_id.rs1_data);
  b  = forwarded_operand(r2, if_id.rs2_data);
  im = expected_imm(if_id.instr);
  case (if_id.instr[14:12])
    3'd0:    cond = a == b;
    3'd1:    cond = a != b;
    3'd4:    cond = $signed(a) < $signed(b);
    3'd5:    cond = !($signed(a) < $signed(b));
    3'd6:    cond = a < b;
    3'd7:    cond = !(a < b);
    default: cond = 1'b0;
  endcase
  e_redir.taken  = v && !e_stall && ((c.branch && cond) || c.jal || c.jalr);
  e_redir.target = c.jalr ? ((a + im) & ~32'h1) : (if_id.pc + im);
  e_ecall        = v && (if_id.instr == INSTR_ECALL);
endtask

// Shadow of the ID/EX register and the flush flag at the next edge
task automatic advance_shadow(input logic e_stall, input redirect_t e_redir);
  logic take;
  if (!hold) begin
    take              = if_id.valid && !sh_flush && !e_stall;
    sh_id_ex.valid    = take;
    sh_id_ex.ctrl     = take ? expected_ctrl(if_id.instr) : '0;
    sh_id_ex.pc       = if_id.pc;
    sh_id_ex.rs1      = if_id.instr[19:15];
    sh_id_ex.rs2      = if_id.instr[24:20];
    sh_id_ex.rd       = if_id.instr[11:7];
    sh_id_ex.rs1_data = if_id.rs1_data;
    sh_id_ex.rs2_data = if_id.rs2_data;
    sh_id_ex.imm      = expected_imm(if_id.instr);
    sh_flush          = e_redir.taken;
  end
endtask

/* tb_decode_stage.sv */
`timescale 1ns/100ps

module tb_decode_stage import rv_decode_pkg::*; ();

  logic      bus;
  logic      arst_n;
  logic      hold;
  if_id_t    if_id;
  fwd_t      ex_mem;
  fwd_t      mem_wb;
  id_ex_t    id_ex;
  redirect_t redirect;
  logic      stall;
  logic      ecall;

  logic [31:0] lfsr;
  int          errors;
  int          checks;
  int          n_load;
  int          n_stall;
  int          n_taken;
  int          n_hold;
  int          n_ecall;

  // Fetch side bookkeeping
  logic  last_stall;
  logic  last_hold;
  logic  wrong_path;
  xlen_t fetch_pc;

  `include "tb_decode_model.svh"

  decode_stage decode_stage_inst (
    .bus      (bus),
    .arst_n   (arst_n),
    .hold     (hold),
    .if_id    (if_id),
    .ex_mem   (ex_mem),
    .mem_wb   (mem_wb),
    .id_ex    (id_ex),
    .redirect (redirect),
    .stall    (stall),
    .ecall    (ecall)
  );

  initial begin
    bus = 1'b0;
    forever #20 bus = ~bus;
  end

  ////////////////////////////////////////
  // Random stimulus
  ////////////////////////////////////////

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Small pool so that hazards are frequent
  function automatic reg_idx_t pick_reg();
    return reg_idx_t'(rand_bits(2));
  endfunction

  // Half small values, so equal compares happen
  function automatic xlen_t draw_data();
    int n;
    n = (rand_bits(1) != 0) ? 2 : 32;
    return rand_bits(n);
  endfunction

  function automatic fwd_t random_fwd();
    fwd_t f;
    f.rd        = pick_reg();
    f.reg_write = rand_bits(1) != 0;
    f.mem_read  = rand_bits(2) == 0;
    f.result    = draw_data();
    return f;
  endfunction

  function automatic logic choose_hold(int level);
    if (level == 2) begin
      return rand_bits(1) != 0;
    end
    return (level == 1) && (rand_bits(3) == 0);
  endfunction

  // Kinds: 0 OP, 1 OP-IMM, 2 load, 3 store, 4 lui, 5 auipc, 6 random word,
  // 7 branch, 8 jal, 9 jalr, 10 ecall
  function automatic xlen_t build_instr(int kind);
    reg_idx_t   rd;
    reg_idx_t   r1;
    reg_idx_t   r2;
    logic [2:0] f3;
    logic [6:0] hi7;
    xlen_t      body;
    rd   = pick_reg();
    r1   = pick_reg();
    r2   = pick_reg();
    f3   = 3'(rand_bits(3));
    body = rand_bits(32);
    hi7  = body[31:25];
    // Mostly legal funct7 for OP and shifts
    if ((kind == 0 || (kind == 1 && f3[1:0] == 2'b01)) && body[1:0] != 2'b00) begin
      hi7 = {1'b0, body[2], 5'b0};
    end
    case (kind)
      0:       return {hi7, r2, r1, f3, rd, OP_REG};
      1:       return {hi7, body[24:20], r1, f3, rd, OP_IMM};
      2:       return {body[31:20], r1, f3, rd, OP_LOAD};
      3:       return {hi7, r2, r1, f3, body[11:7], OP_STORE};
      4:       return {body[31:12], rd, OP_LUI};
      5:       return {body[31:12], rd, OP_AUIPC};
      7:       return {hi7, r2, r1, f3, body[11:7], OP_BRANCH};
      8:       return {body[31:12], rd, OP_JAL};
      9:       return {body[31:20], r1, (body[1:0] == 2'b00) ? f3 : 3'b000, rd, OP_JALR};
      10:      return INSTR_ECALL;
      default: return body;
    endcase
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  // Payload of a bubble is don't-care
  task automatic check_id_ex(id_ex_t got, id_ex_t exp);
    checks++;
    if (got.valid !== exp.valid || got.ctrl !== exp.ctrl || (exp.valid && got !== exp)) begin
      errors++;
      $display("** Error: id_ex got %h expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_redirect(redirect_t got, redirect_t exp);
    checks++;
    if (got.taken !== exp.taken || (exp.taken && got.target !== exp.target)) begin
      errors++;
      $display("** Error: redirect got %h expected %h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////
  // Cycle and test sequencing
  ////////////////////////////////////////

  task automatic run_cycle(input int lo, input int hi, input int hold_level);
    if_id_t    nxt;
    xlen_t     pc_now;
    int        kind;
    logic      e_stall;
    logic      e_ecall;
    redirect_t e_redir;
    @(posedge bus);
    // Fetch re-presents the slot that decode did not take
    if (!(last_stall || last_hold)) begin
      if (wrong_path) begin
        pc_now     = if_id.pc + 32'd4;
        wrong_path = 1'b0;
      end else begin
        pc_now   = fetch_pc;
        fetch_pc = fetch_pc + 32'd4;
      end
      kind         = lo + int'(rand_bits(4)) % (hi - lo + 1);
      nxt.valid    = rand_bits(3) != 0;
      nxt.pc       = pc_now;
      nxt.instr    = build_instr(kind);
      nxt.rs1_data = draw_data();
      nxt.rs2_data = draw_data();
      if_id <= nxt;
    end
    ex_mem <= random_fwd();
    mem_wb <= random_fwd();
    hold   <= choose_hold(hold_level);
    @(negedge bus);
    check_id_ex(id_ex, sh_id_ex);
    predict_outputs(e_stall, e_redir, e_ecall);
    check_flag("stall", stall, e_stall);
    check_redirect(redirect, e_redir);
    check_flag("ecall", ecall, e_ecall);
    n_load  += (!hold && if_id.valid && !sh_flush && !e_stall) ? 1 : 0;
    n_stall += e_stall ? 1 : 0;
    n_taken += e_redir.taken ? 1 : 0;
    n_hold  += hold ? 1 : 0;
    n_ecall += e_ecall ? 1 : 0;
    advance_shadow(e_stall, e_redir);
    if (e_redir.taken && !hold) begin
      fetch_pc   = e_redir.target;
      wrong_path = 1'b1;
    end
    last_stall = e_stall;
    last_hold  = hold;
  endtask

  function automatic int target_count(int sel);
    case (sel)
      1:       return n_stall;
      2:       return n_taken;
      3:       return n_hold;
      4:       return n_ecall;
      default: return n_load;
    endcase
  endfunction

  // Minimum stretch, then wait for enough target events
  task automatic run_phase(input string name, input int lo, input int hi,
                           input int hold_level, input int sel);
    int start_err;
    int n;
    start_err = errors;
    n_load    = 0;
    n_stall   = 0;
    n_taken   = 0;
    n_hold    = 0;
    n_ecall   = 0;
    n         = 0;
    while ((n < 60 || target_count(sel) < 5) && n < 600) begin
      run_cycle(lo, hi, hold_level);
      n++;
    end
    if (target_count(sel) < 5) begin
      errors++;
      $display("%s: timed out after %0d cycles waiting for target events", name, n);
    end
    $display("%-7s %0d cycles, %0d target events, %0d errors",
             name, n, target_count(sel), errors - start_err);
  endtask

  initial begin
    redirect_t no_redir;
    lfsr       = 32'd98364;
    errors     = 0;
    checks     = 0;
    last_stall = 1'b0;
    last_hold  = 1'b0;
    wrong_path = 1'b0;
    fetch_pc   = 32'h0000_1000;
    no_redir   = '0;
    sh_id_ex   = '0;
    sh_flush   = 1'b0;
    arst_n     = 1'b0;
    hold       = 1'b0;
    if_id      = '0;
    ex_mem     = '0;
    mem_wb     = '0;
    repeat (3) @(posedge bus);
    arst_n <= 1'b1;
    @(negedge bus);

    check_id_ex(id_ex, sh_id_ex);
    check_flag("stall", stall, 1'b0);
    check_redirect(redirect, no_redir);
    check_flag("ecall", ecall, 1'b0);
    $display("reset   %0d errors", errors);

    run_phase("decode", 0, 6, 0, 0);
    run_phase("stall", 0, 9, 0, 1);
    run_phase("branch", 7, 9, 0, 2);
    run_phase("hold", 0, 10, 2, 3);
    run_phase("ecall", 7, 10, 1, 4);

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* decode_stage_props.sv */
`timescale 1ns/100ps

module decode_stage_props import rv_decode_pkg::*; (
  input logic      bus,
  input logic      arst_n,
  input logic      hold,
  input logic      stall,
  input id_ex_t    id_ex,
  input redirect_t redirect
);

  // ID/EX frozen across a held edge
  hold_freeze_a: assert property (
    @(posedge bus) disable iff (!arst_n) hold |=> $stable(id_ex)
  ) else $error("id_ex changed across an edge with hold high");

  // Stall inserts a bubble
  stall_bubble_a: assert property (
    @(posedge bus) disable iff (!arst_n) (stall && !hold) |=> !id_ex.valid
  ) else $error("id_ex.valid set after a stall cycle");

  // Wrong-path slot never redirects again
  flush_quiet_a: assert property (
    @(posedge bus) disable iff (!arst_n) (redirect.taken && !hold) |=> !redirect.taken
  ) else $error("redirect.taken repeated in the flushed slot");

endmodule

bind decode_stage decode_stage_props decode_stage_props_inst (
  .bus      (bus),
  .arst_n   (arst_n),
  .hold     (hold),
  .stall    (stall),
  .id_ex    (id_ex),
  .redirect (redirect)
);

/* decode_stage.sv */
`timescale 1ns/100ps

module decode_stage import rv_decode_pkg::*; (
  input  logic      bus,
  input  logic      arst_n,
  input  logic      hold,
  input  if_id_t    if_id,
  input  fwd_t      ex_mem,
  input  fwd_t      mem_wb,
  output id_ex_t    id_ex,
  output redirect_t redirect,
  output logic      stall,
  output logic      ecall
);

  reg_idx_t  rs1;
  reg_idx_t  rs2;
  reg_idx_t  rd;
  ctrl_t     ctrl;
  xlen_t     imm;
  logic      ecall_hit;
  logic      hz_stall;
  redirect_t br_res;
  logic      flush_q;
  logic      eff_valid;
  logic      load_instr;

  // ID/EX register
  logic      valid_q;
  ctrl_t     ctrl_q;
  xlen_t     pc_q;
  reg_idx_t  rs1_q;
  reg_idx_t  rs2_q;
  reg_idx_t  rd_q;
  xlen_t     rs1_data_q;
  xlen_t     rs2_data_q;
  xlen_t     imm_q;

  assign rs1 = if_id.instr[19:15];
  assign rs2 = if_id.instr[24:20];
  assign rd  = if_id.instr[11:7];

  ////////////////////////////////////////
  // Decode units
  ////////////////////////////////////////

  decode_control decode_control_inst (
    .instr     (if_id.instr),
    .ctrl      (ctrl),
    .ecall_hit (ecall_hit)
  );

  imm_gen imm_gen_inst (
    .instr (if_id.instr),
    .imm   (imm)
  );

  hazard_unit hazard_unit_inst (
    .rs1          (rs1),
    .rs2          (rs2),
    .ctrl         (ctrl),
    .ex_rd        (rd_q),
    .ex_mem_read  (ctrl_q.mem_read),
    .ex_reg_write (ctrl_q.reg_write),
    .ex_mem       (ex_mem),
    .stall        (hz_stall)
  );

  branch_unit branch_unit_inst (
    .pc       (if_id.pc),
    .ctrl     (ctrl),
    .funct3   (if_id.instr[14:12]),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (if_id.rs1_data),
    .rs2_data (if_id.rs2_data),
    .imm      (imm),
    .ex_mem   (ex_mem),
    .mem_wb   (mem_wb),
    .redirect (br_res)
  );

  // Wrong-path slot after a taken redirect counts as empty
  assign eff_valid = if_id.valid && !flush_q;

  assign stall = eff_valid && hz_stall;
  assign ecall = eff_valid && ecall_hit;

  // No redirect on stale operands while stalled
  assign redirect.taken  = eff_valid && !hz_stall && br_res.taken;
  assign redirect.target = br_res.target;

  assign load_instr = eff_valid && !hz_stall;

  ////////////////////////////////////////
  // ID/EX register and flush flag
  ////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
      ctrl_q  <= '0;
      flush_q <= 1'b0;
    end else if (!hold) begin
      valid_q <= load_instr;
      ctrl_q  <= load_instr ? ctrl : '0;
      flush_q <= redirect.taken;
    end
  end

  // Payload fields of ID/EX
  always_ff @(posedge bus) begin
    if (!hold) begin
      pc_q       <= if_id.pc;
      rs1_q      <= rs1;
      rs2_q      <= rs2;
      rd_q       <= rd;
      rs1_data_q <= if_id.rs1_data;
      rs2_data_q <= if_id.rs2_data;
      imm_q      <= imm;
    end
  end

  assign id_ex = '{
    valid:    valid_q,
    pc:       pc_q,
    ctrl:     ctrl_q,
    rs1:      rs1_q,
    rs2:      rs2_q,
    rd:       rd_q,
    rs1_data: rs1_data_q,
    rs2_data: rs2_data_q,
    imm:      imm_q
  };

endmodule

/* branch_unit.sv */
`timescale 1ns/100ps

module branch_unit import rv_decode_pkg::*; (
  input  xlen_t      pc,
  input  ctrl_t      ctrl,
  input  logic [2:0] funct3,
  input  reg_idx_t   rs1,
  input  reg_idx_t   rs2,
  input  xlen_t      rs1_data,
  input  xlen_t      rs2_data,
  input  xlen_t      imm,
  input  fwd_t       ex_mem,
  input  fwd_t       mem_wb,
  output redirect_t  redirect
);

  xlen_t op_a;
  xlen_t op_b;
  xlen_t jalr_sum;
  logic  eq;
  logic  lt;
  logic  ltu;
  logic  cond;

  // Newest value of a source register, nearest stage first
  function automatic xlen_t fwd_operand(reg_idx_t idx, xlen_t raw, fwd_t em, fwd_t mw);
    xlen_t val;
    if (idx == '0) begin
      val = '0;
    end else if (em.reg_write && !em.mem_read && (em.rd == idx)) begin
      val = em.result;
    end else if (mw.reg_write && (mw.rd == idx)) begin
      val = mw.result;
    end else begin
      val = raw;
    end
    return val;
  endfunction

  always_comb begin
    op_a = fwd_operand(rs1, rs1_data, ex_mem, mem_wb);
    op_b = fwd_operand(rs2, rs2_data, ex_mem, mem_wb);
  end

  assign eq  = (op_a == op_b);
  assign lt  = ($signed(op_a) < $signed(op_b));
  assign ltu = (op_a < op_b);

  always_comb begin
    case (funct3)
      F3_BEQ:  cond = eq;
      F3_BNE:  cond = !eq;
      F3_BLT:  cond = lt;
      F3_BGE:  cond = !lt;
      F3_BLTU: cond = ltu;
      F3_BGEU: cond = !ltu;
      default: cond = 1'b0;
    endcase
  end

  // Jumps are always taken
  assign redirect.taken = (ctrl.branch && cond) || ctrl.jal || ctrl.jalr;

  ////////////////////////////////////////
  // Redirect target
  ////////////////////////////////////////

  assign jalr_sum = op_a + imm;

  // jalr drops bit 0 of the sum
  assign redirect.target = ctrl.jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;

endmodule

/* hazard_unit.sv */
`timescale 1ns/100ps

module hazard_unit import rv_decode_pkg::*; (
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  input  ctrl_t    ctrl,
  input  reg_idx_t ex_rd,
  input  logic     ex_mem_read,
  input  logic     ex_reg_write,
  input  fwd_t     ex_mem,
  output logic     stall
);

  logic rs1_live;
  logic rs2_live;
  logic id_ex_hit;
  logic ex_mem_hit;
  logic early_use;
  logic load_use;
  logic branch_ex;
  logic branch_mem;

  // x0 never creates a dependence
  assign rs1_live = ctrl.uses_rs1 && (rs1 != '0);
  assign rs2_live = ctrl.uses_rs2 && (rs2 != '0);

  // Matches against the instruction now in ID/EX
  assign id_ex_hit = (rs1_live && (rs1 == ex_rd)) ||
                     (rs2_live && (rs2 == ex_rd));

  // Matches against the instruction now in EX/MEM
  assign ex_mem_hit = (rs1_live && (rs1 == ex_mem.rd)) ||
                      (rs2_live && (rs2 == ex_mem.rd));

  // Branches and jalr need their operands in decode
  assign early_use = ctrl.branch || ctrl.jalr;

  // Load data is not ready until after MEM
  assign load_use = ex_mem_read && id_ex_hit;

  // ALU result not yet available to forward
  assign branch_ex = early_use && ex_reg_write && id_ex_hit;

  // Load still in MEM cannot feed a compare
  assign branch_mem = early_use && ex_mem.mem_read && ex_mem.reg_write && ex_mem_hit;

  assign stall = load_use || branch_ex || branch_mem;

endmodule

/* imm_gen.sv */
`timescale 1ns/100ps

module imm_gen import rv_decode_pkg::*; (
  input  xlen_t instr,
  output xlen_t imm
);

  logic [6:0] opcode;
  logic       sign;

  assign opcode = instr[6:0];
  assign sign   = instr[31];

  always_comb begin
    case (opcode)
      // I-type
      OP_IMM, OP_LOAD, OP_JALR: begin
        imm = {{20{sign}}, instr[31:20]};
      end
      // S-type
      OP_STORE: begin
        imm = {{20{sign}}, instr[31:25], instr[11:7]};
      end
      // B-type, offset in half words
      OP_BRANCH: begin
        imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      // U-type
      OP_LUI, OP_AUIPC: begin
        imm = {instr[31:12], 12'h000};
      end
      // J-type
      OP_JAL: begin
        imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

/* decode_control.sv */
`timescale 1ns/100ps

module decode_control import rv_decode_pkg::*; (
  input  xlen_t instr,
  output ctrl_t ctrl,
  output logic  ecall_hit
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       legal;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign ecall_hit = (instr == INSTR_ECALL);

  // ALU operation for the OP and OP-IMM groups
  function automatic alu_op_e alu_from_f3(logic [2:0] f3, logic alt);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = alt ? ALU_SUB : ALU_ADD;
      F3_SLL:  op = ALU_SLL;
      F3_SLT:  op = ALU_SLT;
      F3_SLTU: op = ALU_SLTU;
      F3_XOR:  op = ALU_XOR;
      F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      F3_OR:   op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl  = '0;
    legal = 1'b1;
    case (opcode)
      OP_LUI: begin
        ctrl.reg_write   = 1'b1;
        ctrl.lui         = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = ALU_PASS_B;
      end
      OP_AUIPC: begin
        ctrl.reg_write   = 1'b1;
        ctrl.auipc       = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.jal       = 1'b1;
      end
      OP_JALR: begin
        legal            = (funct3 == 3'b000);
        ctrl.reg_write   = 1'b1;
        ctrl.jalr        = 1'b1;
        ctrl.uses_rs1    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      OP_BRANCH: begin
        // 010 and 011 are unassigned
        legal         = (funct3[2:1] != 2'b01);
        ctrl.branch   = 1'b1;
        ctrl.uses_rs1 = 1'b1;
        ctrl.uses_rs2 = 1'b1;
        ctrl.alu_op   = ALU_SUB;
      end
      OP_LOAD: begin
        // LB LH LW LBU LHU
        legal            = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
        ctrl.mem_read    = 1'b1;
        ctrl.reg_write   = 1'b1;
        ctrl.mem_size    = funct3;
        ctrl.uses_rs1    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      OP_STORE: begin
        legal            = !funct3[2] && (funct3[1:0] != 2'b11);
        ctrl.mem_write   = 1'b1;
        ctrl.mem_size    = funct3;
        ctrl.uses_rs1    = 1'b1;
        ctrl.uses_rs2    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
      end
      OP_IMM: begin
        // Shift amounts share the funct7 field, other immediates do not
        if (funct3 == F3_SLL) begin
          legal = (funct7 == F7_BASE);
        end else if (funct3 == F3_SR) begin
          legal = (funct7 == F7_BASE) || (funct7 == F7_ALT);
        end
        ctrl.reg_write   = 1'b1;
        ctrl.uses_rs1    = 1'b1;
        ctrl.alu_src_imm = 1'b1;
        ctrl.alu_op      = alu_from_f3(funct3, (funct3 == F3_SR) && (funct7 == F7_ALT));
      end
      OP_REG: begin
        legal = (funct7 == F7_BASE) ||
                ((funct7 == F7_ALT) && ((funct3 == F3_ADD) || (funct3 == F3_SR)));
        ctrl.reg_write = 1'b1;
        ctrl.uses_rs1  = 1'b1;
        ctrl.uses_rs2  = 1'b1;
        ctrl.alu_op    = alu_from_f3(funct3, funct7 == F7_ALT);
      end
      OP_SYSTEM: begin
        // Only ecall is supported here
        legal = ecall_hit;
      end
      default: begin
        legal = 1'b0;
      end
    endcase

    // Unknown encodings decode to a no-op marked illegal
    if (!legal) begin
      ctrl         = '0;
      ctrl.illegal = 1'b1;
    end
  end

endmodule

/* rv_decode_pkg.sv */
package rv_decode_pkg;

  ////////////////////////////////////////
  // Widths and basic types
  ////////////////////////////////////////

  localparam int XLEN      = 32;
  localparam int REG_IDX_W = 5;

  typedef logic [XLEN-1:0]      xlen_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  ////////////////////////////////////////
  // RV32I encodings
  ////////////////////////////////////////

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam xlen_t INSTR_ECALL = 32'h0000_0073;

  // Branch compare selects
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Integer ALU selects for OP and OP-IMM
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  // ADD must stay at zero so a cleared control word is a no-op
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  ////////////////////////////////////////
  // Stage structs
  ////////////////////////////////////////

  typedef struct packed {
    alu_op_e    alu_op;
    logic       alu_src_imm;
    logic       mem_read;
    logic       mem_write;
    logic [2:0] mem_size;
    logic       reg_write;
    logic       branch;
    logic       jal;
    logic       jalr;
    logic       lui;
    logic       auipc;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       illegal;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    xlen_t pc;
    xlen_t instr;
    xlen_t rs1_data;
    xlen_t rs2_data;
  } if_id_t;

  typedef struct packed {
    logic     valid;
    xlen_t    pc;
    ctrl_t    ctrl;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    xlen_t    imm;
  } id_ex_t;

  // State of a later stage seen from decode
  typedef struct packed {
    reg_idx_t rd;
    logic     reg_write;
    logic     mem_read;
    xlen_t    result;
  } fwd_t;

  typedef struct packed {
    logic  taken;
    xlen_t target;
  } redirect_t;

endpackage
